// File: verilog/histPkg.sv
package histPkg;

    // sample width and bin address width
    localparam int NP = 8;
    localparam int NB = 4;

    // frame geometry defaults
    // the top level overrides these through its own parameters
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM = 3;
    localparam int ACQ_NUM = 2;

    // wide enough for DATA_NUM * ACQ_NUM hits in one bin
    localparam int COUNT_W = 6;

    // raw sample value
    typedef logic [NP-1:0] sample_t;

    // histogram bin address, coarse or fine
    typedef logic [NB-1:0] bin_t;

    // pixel index, up to four pixels
    typedef logic [1:0] pixel_t;

    // hit count of one bin
    typedef logic [COUNT_W-1:0] count_t;

    // pass state
    // coarse and fine collect samples, report streams results,
    // clear wipes the histogram between passes
    typedef enum logic [1:0] {
        PASS_COARSE,
        PASS_FINE,
        PASS_REPORT,
        PASS_CLEAR
    } pass_t;

endpackage

// File: verilog/countBus.sv
`timescale 1ns/1ps

// one updated bin count, from the histogram memory to the peak tracker
interface countBus;

    // single cycle strobe, one per binned sample
    logic valid;

    // pixel that owns the bin
    histPkg::pixel_t pixel;

    // bin address inside that pixel's histogram
    histPkg::bin_t bin;

    // bin count after the increment
    histPkg::count_t count;

    // memory side drives everything
    modport ram (
        output valid,
        output pixel,
        output bin,
        output count
    );

    // tracker side only listens
    modport tracker (
        input valid,
        input pixel,
        input bin,
        input count
    );

endinterface

// File: verilog/passSequencer.sv
`timescale 1ns/1ps

module passSequencer #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int DATA_NUM = histPkg::DATA_NUM,
    parameter int ACQ_NUM = histPkg::ACQ_NUM
) (
    input logic clk,
    input logic combin_res,
    input logic sampleValid,
    output logic accept,
    output histPkg::pixel_t pixel,
    output histPkg::pass_t pass,
    output logic clear,
    output logic busy
);

    // counter widths, at least one bit each
    localparam int IN_W = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    logic [IN_W-1:0] inputCount;
    logic [ACQ_W-1:0] acqCount;
    logic inputLast;
    logic pixelLast;
    logic acqLast;
    logic passLast;
    // pass toggle, high once the coarse histogram has been taken
    logic fineSel;

    // samples are dropped while busy
    assign accept = sampleValid && !busy;

    assign inputLast = (inputCount == IN_W'(DATA_NUM - 1));
    assign pixelLast = (pixel == histPkg::pixel_t'(PIXEL_NUM - 1));
    assign acqLast = (acqCount == ACQ_W'(ACQ_NUM - 1));

    // final sample of the whole pass
    assign passLast = accept && inputLast && pixelLast && acqLast;

    assign clear = (pass == histPkg::PASS_CLEAR);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            inputCount <= '0;
            acqCount <= '0;
            pixel <= '0;
            pass <= histPkg::PASS_COARSE;
            busy <= 1'b0;
            fineSel <= 1'b0;
        end else begin
            case (pass)
                histPkg::PASS_COARSE, histPkg::PASS_FINE: begin
                    if (busy) begin
                        // drain cycle, last count reaches the tracker
                        if (pass == histPkg::PASS_COARSE) begin
                            pass <= histPkg::PASS_CLEAR;
                        end else begin
                            pass <= histPkg::PASS_REPORT;
                        end
                    end else if (accept) begin
                        // sample -> pixel -> acquisition nesting
                        if (inputLast) begin
                            inputCount <= '0;
                            if (pixelLast) begin
                                pixel <= '0;
                                if (acqLast) begin
                                    acqCount <= '0;
                                end else begin
                                    acqCount <= acqCount + 1'b1;
                                end
                            end else begin
                                pixel <= pixel + 1'b1;
                            end
                        end else begin
                            inputCount <= inputCount + 1'b1;
                        end
                        if (passLast) begin
                            busy <= 1'b1;
                        end
                    end
                end
                histPkg::PASS_REPORT: begin
                    // pixel counter doubles as report index
                    if (pixelLast) begin
                        pixel <= '0;
                        pass <= histPkg::PASS_CLEAR;
                    end else begin
                        pixel <= pixel + 1'b1;
                    end
                end
                histPkg::PASS_CLEAR: begin
                    // single clear cycle, then pick the next pass
                    busy <= 1'b0;
                    fineSel <= !fineSel;
                    if (fineSel) begin
                        pass <= histPkg::PASS_COARSE;
                    end else begin
                        pass <= histPkg::PASS_FINE;
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/binMapper.sv
`timescale 1ns/1ps

module binMapper (
    input logic accept,
    input histPkg::sample_t sample,
    input histPkg::pass_t pass,
    input histPkg::bin_t coarseBin,
    output logic hit,
    output histPkg::bin_t bin,
    output histPkg::sample_t windowLow
);

    // coarse bin to sample scale
    localparam int SHIFT = histPkg::NP - histPkg::NB;

    // half window below the centre
    localparam histPkg::sample_t HALF = histPkg::sample_t'(2 ** (histPkg::NB - 1));

    // window spans one full fine histogram
    localparam histPkg::sample_t SPAN = histPkg::sample_t'(2 ** histPkg::NB - 1);

    // highest low edge that keeps the window inside the sample range
    localparam histPkg::sample_t LOW_MAX =
        histPkg::sample_t'(2 ** histPkg::NP - 2 ** histPkg::NB);

    histPkg::sample_t centre;
    histPkg::sample_t windowHigh;
    logic inWindow;

    assign centre = histPkg::sample_t'(coarseBin) << SHIFT;

    // low edge with clamping at both ends
    always_comb begin
        if (centre < HALF) begin
            windowLow = '0;
        end else if ((centre - HALF) > LOW_MAX) begin
            windowLow = LOW_MAX;
        end else begin
            windowLow = centre - HALF;
        end
    end

    // cannot overflow, low edge is at most LOW_MAX
    assign windowHigh = windowLow + SPAN;

    assign inWindow = (sample >= windowLow) && (sample <= windowHigh);

    always_comb begin
        case (pass)
            histPkg::PASS_COARSE: begin
                // top bits pick the coarse bin
                hit = accept;
                bin = sample[histPkg::NP-1 -: histPkg::NB];
            end
            histPkg::PASS_FINE: begin
                // unit resolution relative to the low edge
                // outside samples are still counted by the sequencer
                hit = accept && inWindow;
                bin = histPkg::bin_t'(sample - windowLow);
            end
            default: begin
                hit = 1'b0;
                bin = sample[histPkg::NP-1 -: histPkg::NB];
            end
        endcase
    end

endmodule

// File: verilog/binCounterRam.sv
`timescale 1ns/1ps

module binCounterRam #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM
) (
    input logic clk,
    input logic combin_res,
    input logic hit,
    input histPkg::pixel_t pixel,
    input histPkg::bin_t bin,
    input logic clear,
    countBus.ram counts
);

    localparam int BINS = 2 ** histPkg::NB;
    localparam int DEPTH = PIXEL_NUM * BINS;
    localparam int ADDR_W = $bits(histPkg::pixel_t) + histPkg::NB;

    // all pixel histograms side by side
    histPkg::count_t mem [DEPTH];

    // one bit per bin, a cleared bit means count zero
    logic [DEPTH-1:0] binValid;

    logic [ADDR_W-1:0] addr;
    histPkg::count_t nextCount;

    // pixel picks the histogram, bin the entry
    assign addr = {pixel, bin};

    // read-modify-write, a stale entry restarts at one
    assign nextCount = binValid[addr] ? histPkg::count_t'(mem[addr] + 1'b1)
                                      : histPkg::count_t'(1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            counts.valid <= 1'b0;
        end else begin
            counts.valid <= hit;
            // whole memory empties in one cycle
            if (clear) begin
                binValid <= '0;
            end else if (hit) begin
                binValid[addr] <= 1'b1;
            end
        end
    end

    // count storage and the outgoing update
    always_ff @(posedge clk) begin
        if (hit) begin
            mem[addr] <= nextCount;
            counts.pixel <= pixel;
            counts.bin <= bin;
            counts.count <= nextCount;
        end
    end

endmodule

// File: verilog/peakTracker.sv
`timescale 1ns/1ps

module peakTracker #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM
) (
    input logic clk,
    input logic combin_res,
    input histPkg::pass_t pass,
    input histPkg::pixel_t pixel,
    input histPkg::sample_t windowLow,
    input logic clear,
    countBus.tracker counts,
    output histPkg::bin_t coarseBin,
    output logic resultValid,
    output histPkg::pixel_t resultPixel,
    output histPkg::bin_t resultCoarse,
    output histPkg::sample_t resultFine
);

    // running maximum and its bin, per pixel
    histPkg::count_t maxCount [PIXEL_NUM];
    histPkg::bin_t peakBin [PIXEL_NUM];

    // coarse peak and fine window low edge, per pixel
    histPkg::bin_t coarseStore [PIXEL_NUM];
    histPkg::sample_t lowStore [PIXEL_NUM];

    // set once the fine results went out
    // tells the two clear cycles apart
    logic reported;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                maxCount[i] <= '0;
                peakBin[i] <= '0;
            end
            reported <= 1'b0;
        end else begin
            if (clear) begin
                for (int i = 0; i < PIXEL_NUM; i++) begin
                    maxCount[i] <= '0;
                    peakBin[i] <= '0;
                end
                reported <= 1'b0;
            end else begin
                // strictly greater, a tie keeps the earlier bin
                if (counts.valid && (counts.count > maxCount[counts.pixel])) begin
                    maxCount[counts.pixel] <= counts.count;
                    peakBin[counts.pixel] <= counts.bin;
                end
                if (pass == histPkg::PASS_REPORT) begin
                    reported <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // end of coarse pass, peaks become window centres
        if (clear && !reported) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                coarseStore[i] <= peakBin[i];
            end
        end
        // low edge of the pixel being sampled
        if (pass == histPkg::PASS_FINE) begin
            lowStore[pixel] <= windowLow;
        end
    end

    // window lookup for the mapper
    assign coarseBin = coarseStore[pixel];

    // one pixel per report cycle
    assign resultValid = (pass == histPkg::PASS_REPORT);
    assign resultPixel = pixel;
    assign resultCoarse = coarseStore[pixel];

    // absolute fine peak
    assign resultFine = lowStore[pixel] + histPkg::sample_t'(peakBin[pixel]);

endmodule

// File: verilog/peakHistogram.sv
`timescale 1ns/1ps

module peakHistogram #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int DATA_NUM = histPkg::DATA_NUM,
    parameter int ACQ_NUM = histPkg::ACQ_NUM
) (
    input logic clk,
    input logic combin_res,
    input logic sampleValid,
    input histPkg::sample_t sample,
    output logic busy,
    output logic resultValid,
    output histPkg::pixel_t resultPixel,
    output histPkg::bin_t resultCoarse,
    output histPkg::sample_t resultFine
);

    // sequencer outputs
    logic accept;
    histPkg::pixel_t pixel;
    histPkg::pass_t pass;
    logic clear;

    // mapper outputs
    logic hit;
    histPkg::bin_t bin;
    histPkg::sample_t windowLow;

    // coarse peak of the current pixel
    histPkg::bin_t coarseBin;

    // bin updates, memory to tracker
    countBus counts ();

    passSequencer #(
        .PIXEL_NUM(PIXEL_NUM),
        .DATA_NUM(DATA_NUM),
        .ACQ_NUM(ACQ_NUM)
    ) uSequencer (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .accept(accept),
        .pixel(pixel),
        .pass(pass),
        .clear(clear),
        .busy(busy)
    );

    binMapper uMapper (
        .accept(accept),
        .sample(sample),
        .pass(pass),
        .coarseBin(coarseBin),
        .hit(hit),
        .bin(bin),
        .windowLow(windowLow)
    );

    binCounterRam #(
        .PIXEL_NUM(PIXEL_NUM)
    ) uRam (
        .clk(clk),
        .combin_res(combin_res),
        .hit(hit),
        .pixel(pixel),
        .bin(bin),
        .clear(clear),
        .counts(counts)
    );

    peakTracker #(
        .PIXEL_NUM(PIXEL_NUM)
    ) uTracker (
        .clk(clk),
        .combin_res(combin_res),
        .pass(pass),
        .pixel(pixel),
        .windowLow(windowLow),
        .clear(clear),
        .counts(counts),
        .coarseBin(coarseBin),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .resultCoarse(resultCoarse),
        .resultFine(resultFine)
    );

endmodule

// File: include/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare one observed value with its expected value, stop on mismatch
task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("Result: FAILED");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// wait for resultValid on clk of the including testbench
// sampled mid cycle, returns in the first report cycle
task automatic waitResult(input int maxCycles);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (resultValid !== 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > maxCycles) begin
            $display("timeout after %0d cycles while waiting for the first result",
                     maxCycles);
            $display("Result: FAILED");
            $fatal(1, "result timeout");
        end
    end
endtask

// window rule, low edge with clamping
function automatic histPkg::sample_t modelWindowLow(input histPkg::bin_t coarse);
    int low;
    low = (int'(coarse) << (histPkg::NP - histPkg::NB)) - 2 ** (histPkg::NB - 1);
    if (low < 0) begin
        low = 0;
    end
    if (low > 2 ** histPkg::NP - 2 ** histPkg::NB) begin
        low = 2 ** histPkg::NP - 2 ** histPkg::NB;
    end
    return histPkg::sample_t'(low);
endfunction

// peak rule over one pixel's samples in arrival order
// fine mode bins only inside the window starting at low
function automatic histPkg::bin_t modelPeak(input histPkg::sample_t samples[$],
                                            input bit fine,
                                            input histPkg::sample_t low);
    int hist [2 ** histPkg::NB];
    int maxCount;
    int b;
    histPkg::bin_t peak;
    foreach (hist[i]) begin
        hist[i] = 0;
    end
    maxCount = 0;
    peak = '0;
    foreach (samples[i]) begin
        if (!fine) begin
            b = int'(samples[i][histPkg::NP-1 -: histPkg::NB]);
        end else if (int'(samples[i]) >= int'(low) &&
                     int'(samples[i]) <= int'(low) + 2 ** histPkg::NB - 1) begin
            b = int'(samples[i]) - int'(low);
        end else begin
            continue;
        end
        hist[b]++;
        // strictly greater keeps the earlier bin on a tie
        if (hist[b] > maxCount) begin
            maxCount = hist[b];
            peak = histPkg::bin_t'(b);
        end
    end
    return peak;
endfunction

// absolute fine value for a pixel with a known coarse peak
function automatic histPkg::sample_t modelFine(input histPkg::sample_t samples[$],
                                               input histPkg::bin_t coarse);
    histPkg::sample_t low;
    low = modelWindowLow(coarse);
    return low + histPkg::sample_t'(modelPeak(samples, 1'b1, low));
endfunction

`endif

// File: tb/tbPeakHistogram.sv
`timescale 1ns/1ps

module tbPeakHistogram;

    localparam int PIXELS = 4;
    localparam int DATA = 3;
    localparam int ACQ = 2;
    // samples per pixel in one pass, and per pass overall
    localparam int PER_PIXEL = DATA * ACQ;
    localparam int TOTAL = PIXELS * PER_PIXEL;
    localparam int TIMEOUT = 200;

    logic clk;
    logic combin_res;
    logic sampleValid;
    histPkg::sample_t sample;
    logic busy;
    logic resultValid;
    histPkg::pixel_t resultPixel;
    histPkg::bin_t resultCoarse;
    histPkg::sample_t resultFine;

    // one frame of stimulus, index 0 coarse pass, 1 fine pass
    histPkg::sample_t frame [2][TOTAL];

    `include "tbChecks.svh"

    peakHistogram #(
        .PIXEL_NUM(PIXELS),
        .DATA_NUM(DATA),
        .ACQ_NUM(ACQ)
    ) i_dut (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sample(sample),
        .busy(busy),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .resultCoarse(resultCoarse),
        .resultFine(resultFine)
    );

    always #20 clk = ~clk;

    // stream position of sample j of pixel p
    // whole acquisitions arrive one after the other
    function automatic int slot(input int p, input int j);
        return (j / DATA) * PIXELS * DATA + p * DATA + (j % DATA);
    endfunction

    // samples of one pixel in arrival order
    function automatic void pixelSamples(input int sel, input int p,
                                         output histPkg::sample_t q[$]);
        q = {};
        for (int j = 0; j < PER_PIXEL; j++) begin
            q.push_back(frame[sel][slot(p, j)]);
        end
    endfunction

    function automatic histPkg::bin_t expectedCoarse(input int p);
        histPkg::sample_t q[$];
        pixelSamples(0, p, q);
        return modelPeak(q, 1'b0, histPkg::sample_t'(0));
    endfunction

    // sampled mid cycle, where busy is stable
    task automatic waitIdle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout while waiting for busy to fall");
                $display("Result: FAILED");
                $fatal(1, "busy stuck high");
            end
        end
    endtask

    task automatic sendPass(input int sel);
        for (int k = 0; k < TOTAL; k++) begin
            @(posedge clk);
            sampleValid <= 1'b1;
            sample <= frame[sel][k];
        end
        // stray repeat of pixel 0's first sample while busy, must not be counted
        @(posedge clk);
        sample <= frame[sel][0];
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    // both passes, then the report against the model
    task automatic runFrame();
        histPkg::sample_t q[$];
        histPkg::bin_t expCoarse [PIXELS];
        histPkg::sample_t expFine [PIXELS];
        for (int p = 0; p < PIXELS; p++) begin
            expCoarse[p] = expectedCoarse(p);
            pixelSamples(1, p, q);
            expFine[p] = modelFine(q, expCoarse[p]);
        end
        waitIdle();
        sendPass(0);
        @(negedge clk);
        checkValue("busy", 32'(busy), 32'd1);
        waitIdle();
        sendPass(1);
        waitResult(TIMEOUT);
        for (int p = 0; p < PIXELS; p++) begin
            if (p > 0) begin
                @(negedge clk);
            end
            checkValue("resultValid", 32'(resultValid), 32'd1);
            checkValue("resultPixel", 32'(resultPixel), 32'(p));
            checkValue("resultCoarse", 32'(resultCoarse), 32'(expCoarse[p]));
            checkValue("resultFine", 32'(resultFine), 32'(expFine[p]));
        end
        // exactly one result per pixel
        @(negedge clk);
        checkValue("resultValid", 32'(resultValid), 32'd0);
    endtask

    task automatic testReset();
        @(negedge clk);
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("resultValid", 32'(resultValid), 32'd0);
    endtask

    // clusters mid range, one outlier per pixel
    task automatic testInterior(input int shift);
        int offs [PER_PIXEL];
        histPkg::sample_t low;
        offs = '{3, 7, 11, 7, 3, 7};
        for (int p = 0; p < PIXELS; p++) begin
            for (int j = 0; j < PER_PIXEL; j++) begin
                frame[0][slot(p, j)] = histPkg::sample_t'(72 + 33 * p + 3 * j + shift);
            end
            frame[0][slot(p, 5)] = histPkg::sample_t'(200 - 33 * p);
            low = modelWindowLow(expectedCoarse(p));
            for (int j = 0; j < PER_PIXEL; j++) begin
                frame[1][slot(p, j)] = low + histPkg::sample_t'((offs[j] + p + shift) % 16);
            end
        end
        runFrame();
    endtask

    // peaks at both ends of the sample range
    task automatic testClamped();
        int lowOffs [PER_PIXEL];
        int highOffs [PER_PIXEL];
        lowOffs = '{2, 5, 5, 9, 2, 5};
        highOffs = '{255, 250, 255, 241, 250, 255};
        for (int p = 0; p < PIXELS; p++) begin
            for (int j = 0; j < PER_PIXEL; j++) begin
                if (p < 2) begin
                    frame[0][slot(p, j)] = histPkg::sample_t'(1 + j + p);
                    frame[1][slot(p, j)] = histPkg::sample_t'(lowOffs[j] + p);
                end else begin
                    frame[0][slot(p, j)] = histPkg::sample_t'(250 - j);
                    frame[1][slot(p, j)] = histPkg::sample_t'(highOffs[j] - p);
                end
            end
        end
        runFrame();
    endtask

    // coarse tie between two bins, fine samples partly outside the window
    task automatic testFilterTies();
        int offs [PER_PIXEL];
        histPkg::sample_t low;
        // offset 21 would alias onto bin 5 if it were binned
        offs = '{5, 9, 21, 9, 21, 5};
        for (int p = 0; p < PIXELS; p++) begin
            for (int j = 0; j < PER_PIXEL; j++) begin
                if (j % 2 == 0) begin
                    frame[0][slot(p, j)] = histPkg::sample_t'(((p + 4) << 4) + j);
                end else begin
                    frame[0][slot(p, j)] = histPkg::sample_t'(((p + 8) << 4) + j);
                end
            end
            low = modelWindowLow(expectedCoarse(p));
            for (int j = 0; j < PER_PIXEL; j++) begin
                frame[1][slot(p, j)] = low + histPkg::sample_t'(offs[j]);
            end
        end
        runFrame();
    endtask

    // fixed frame, then a random one right behind it
    task automatic testBackToBack();
        histPkg::sample_t low;
        testInterior(5);
        for (int p = 0; p < PIXELS; p++) begin
            for (int j = 0; j < PER_PIXEL; j++) begin
                frame[0][slot(p, j)] = histPkg::sample_t'($urandom);
            end
            low = modelWindowLow(expectedCoarse(p));
            for (int j = 0; j < PER_PIXEL; j++) begin
                frame[1][slot(p, j)] = low + histPkg::sample_t'($urandom % 24);
            end
        end
        runFrame();
    endtask

    initial begin
        clk = 1'b0;
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        void'($urandom(32'h64ca));
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        testReset();
        testInterior(0);
        testClamped();
        testFilterTies();
        testBackToBack();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
verilog/histPkg.sv
verilog/countBus.sv
verilog/passSequencer.sv
verilog/binMapper.sv
verilog/binCounterRam.sv
verilog/peakTracker.sv
verilog/peakHistogram.sv
tb/tbPeakHistogram.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for failure
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tbPeakHistogram \
    -f compile.f -o simPeakHistogram \
    && ./obj_dir/simPeakHistogram > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
